// File: verilog/pcie_if_pkg.sv
package pcie_if_pkg;

    // Datapath width of the single receive segment
    localparam int TLP_DATA_WIDTH = 128;

    // Configuration bus addresses
    localparam logic [4:0] CFG_ADDR_DEVCTL   = 5'h00;
    localparam logic [4:0] CFG_ADDR_BUSNUM   = 5'h02;
    localparam logic [4:0] CFG_ADDR_MSI_MASK = 5'h0c;
    localparam logic [4:0] CFG_ADDR_MSI_CTL  = 5'h12;

    // Device control field positions
    localparam int DEVCTL_MPS_LSB     = 5;
    localparam int DEVCTL_EXT_TAG_BIT = 8;
    localparam int DEVCTL_MRRS_LSB    = 12;

    // MSI control field positions
    localparam int MSI_CTL_EN_BIT  = 0;
    localparam int MSI_CTL_MME_LSB = 4;

    // TLP type field in the first header dword
    localparam int         TLP_TYPE_LSB = 24;
    localparam logic [4:0] TLP_TYPE_CPL = 5'b01010;

    // Range code the IP core reports for IO space
    localparam logic [2:0] BAR_RANGE_IO = 3'd6;

    // Beat on the request path
    typedef struct packed {
        logic [TLP_DATA_WIDTH-1:0] data;
        logic                      sop;
        logic                      eop;
        logic [2:0]                bar_id;
    } rx_beat_t;

    // Beat on the completion path
    typedef struct packed {
        logic [TLP_DATA_WIDTH-1:0] data;
        logic                      sop;
        logic                      eop;
    } cpl_beat_t;

endpackage

// File: verilog/pcie_cfg_decode.sv
`timescale 1ns/1ns

module pcie_cfg_decode #(
    parameter int PF_COUNT = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Rotating configuration bus from the IP core
    input  logic [31:0]           tl_cfg_ctl,
    input  logic [4:0]            tl_cfg_add,
    input  logic [1:0]            tl_cfg_func,

    // Per-function settings
    output logic [PF_COUNT-1:0]   ext_tag_enable,
    output logic [PF_COUNT*3-1:0] max_payload_size,
    output logic [PF_COUNT*3-1:0] max_read_request_size,
    output logic [7:0]            bus_num,

    // MSI settings of PF 0
    output logic                  msi_enable,
    output logic [2:0]            msi_mme,
    output logic [31:0]           msi_mask
);

    logic func_valid;
    logic func_zero;

    // Functions beyond the configured count are not implemented
    assign func_valid = int'(tl_cfg_func) < PF_COUNT;
    assign func_zero  = tl_cfg_func == 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_tag_enable        <= '0;
            max_payload_size      <= '0;
            max_read_request_size <= '0;
            bus_num               <= '0;
        end else if (func_valid) begin
            if (tl_cfg_add == pcie_if_pkg::CFG_ADDR_BUSNUM) begin
                // Single bus number for the whole device
                bus_num <= tl_cfg_ctl[7:0];
            end
            for (int f = 0; f < PF_COUNT; f++) begin
                if (tl_cfg_func == 2'(f) && tl_cfg_add == pcie_if_pkg::CFG_ADDR_DEVCTL) begin
                    ext_tag_enable[f] <= tl_cfg_ctl[pcie_if_pkg::DEVCTL_EXT_TAG_BIT];
                    max_payload_size[f*3 +: 3] <=
                        tl_cfg_ctl[pcie_if_pkg::DEVCTL_MPS_LSB +: 3];
                    max_read_request_size[f*3 +: 3] <=
                        tl_cfg_ctl[pcie_if_pkg::DEVCTL_MRRS_LSB +: 3];
                end
            end
        end
    end

    // MSI is only tracked for PF 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msi_enable <= 1'b0;
            msi_mme    <= '0;
            msi_mask   <= '0;
        end else if (func_zero) begin
            case (tl_cfg_add)
                pcie_if_pkg::CFG_ADDR_MSI_CTL: begin
                    msi_enable <= tl_cfg_ctl[pcie_if_pkg::MSI_CTL_EN_BIT];
                    msi_mme    <= tl_cfg_ctl[pcie_if_pkg::MSI_CTL_MME_LSB +: 3];
                end
                pcie_if_pkg::CFG_ADDR_MSI_MASK: begin
                    msi_mask <= tl_cfg_ctl;
                end
            endcase
        end
    end

    // The IP core drives the address every cycle once out of reset
    cfg_add_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(tl_cfg_add)
    ) else $error("tl_cfg_add is unknown");

endmodule

// File: verilog/pcie_msi_gen.sv
`timescale 1ns/1ns

module pcie_msi_gen #(
    // At most 32 vectors fit the 5-bit message number
    parameter int MSI_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Interrupt sources, edge sensitive
    input  logic [MSI_COUNT-1:0] msi_irq,

    // Captured MSI configuration
    input  logic                 msi_enable,
    input  logic [2:0]           msi_mme,
    input  logic [31:0]          msi_mask,

    // Request port of the IP core
    output logic                 app_msi_req,
    input  logic                 app_msi_ack,
    output logic [4:0]           app_msi_num
);

    logic [MSI_COUNT-1:0] irq_prev;
    logic [MSI_COUNT-1:0] irq_rise;
    logic [MSI_COUNT-1:0] pending;
    logic [MSI_COUNT-1:0] eligible;
    logic [MSI_COUNT-1:0] clear_mask;
    logic [7:0]           vec_limit;
    logic                 ack_fire;
    logic                 found;
    logic [4:0]           next_num;

    assign irq_rise = msi_irq & ~irq_prev;
    assign ack_fire = app_msi_req && app_msi_ack;

    // Number of vectors granted by the multiple message enable field
    assign vec_limit = 8'd1 << msi_mme;

    always_comb begin
        for (int i = 0; i < MSI_COUNT; i++) begin
            eligible[i] = pending[i] && !msi_mask[i] && msi_enable && (i < vec_limit);
            clear_mask[i] = ack_fire && (app_msi_num == 5'(i));
        end
    end

    // Lowest index wins
    always_comb begin
        next_num = '0;
        for (int i = MSI_COUNT - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                next_num = 5'(i);
            end
        end
    end

    assign found = |eligible;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_prev    <= '0;
            pending     <= '0;
            app_msi_req <= 1'b0;
            app_msi_num <= '0;
        end else begin
            irq_prev <= msi_irq;
            // A fresh edge in the ack cycle survives the clear
            pending  <= (pending & ~clear_mask) | irq_rise;

            if (ack_fire) begin
                app_msi_req <= 1'b0;
            end else if (!app_msi_req && found) begin
                app_msi_req <= 1'b1;
                app_msi_num <= next_num;
            end
        end
    end

    // Request and vector stay put until the core acknowledges
    msi_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        app_msi_req && !app_msi_ack |=> app_msi_req && $stable(app_msi_num)
    ) else $error("MSI request changed before ack");

endmodule

// File: verilog/pcie_rx_demux.sv
`timescale 1ns/1ns

module pcie_rx_demux #(
    parameter int IO_BAR_INDEX = 5
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // Receive stream from the IP core
    input  logic [pcie_if_pkg::TLP_DATA_WIDTH-1:0]  rx_st_data,
    input  logic                                    rx_st_sop,
    input  logic                                    rx_st_eop,
    input  logic                                    rx_st_valid,
    input  logic [2:0]                              rx_st_bar_range,
    output logic                                    rx_st_ready,

    // Request path towards the BARs
    output pcie_if_pkg::rx_beat_t                   req_beat,
    output logic                                    req_valid,
    input  logic                                    req_ready,

    // Completion path towards DMA
    output pcie_if_pkg::cpl_beat_t                  cpl_beat,
    output logic                                    cpl_valid,
    input  logic                                    cpl_ready
);

    logic       in_pkt;
    logic       route_cpl_q;
    logic [2:0] bar_id_q;
    logic       fire;
    logic       sop_is_cpl;
    logic [2:0] sop_bar_id;
    logic       route_cpl;
    logic [2:0] bar_id;

    // Both paths must have room so a beat never splits
    assign rx_st_ready = req_ready && cpl_ready;
    assign fire        = rx_st_valid && rx_st_ready;

    assign sop_is_cpl = rx_st_data[pcie_if_pkg::TLP_TYPE_LSB +: 5] == pcie_if_pkg::TLP_TYPE_CPL;
    assign sop_bar_id = (rx_st_bar_range == pcie_if_pkg::BAR_RANGE_IO) ?
                        3'(IO_BAR_INDEX) : rx_st_bar_range;

    // Sop beats decide for themselves, later beats follow the packet
    assign route_cpl = rx_st_sop ? sop_is_cpl : route_cpl_q;
    assign bar_id    = rx_st_sop ? sop_bar_id : bar_id_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt      <= 1'b0;
            route_cpl_q <= 1'b0;
        end else if (fire) begin
            if (rx_st_sop) begin
                route_cpl_q <= sop_is_cpl;
            end
            in_pkt <= !rx_st_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && rx_st_sop) begin
            bar_id_q <= sop_bar_id;
        end
    end

    assign req_valid       = fire && !route_cpl;
    assign req_beat.data   = rx_st_data;
    assign req_beat.sop    = rx_st_sop;
    assign req_beat.eop    = rx_st_eop;
    assign req_beat.bar_id = bar_id;

    assign cpl_valid     = fire && route_cpl;
    assign cpl_beat.data = rx_st_data;
    assign cpl_beat.sop  = rx_st_sop;
    assign cpl_beat.eop  = rx_st_eop;

    // Each packet closes with eop before the next one opens
    rx_sop_framing: assert property (
        @(posedge clk) disable iff (!rst_n) fire && rx_st_sop |-> !in_pkt
    ) else $error("sop accepted inside an open packet");

endmodule

// File: verilog/pcie_tlp_reg.sv
`timescale 1ns/1ns

module pcie_tlp_reg #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst_n,

    // Upstream side
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    // Downstream side
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    // Room when empty or when the held beat leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // Held beat stays intact while stalled
    out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("output changed while stalled");

endmodule

// File: verilog/pcie_if_top.sv
`timescale 1ns/1ns

module pcie_if_top #(
    parameter int PF_COUNT     = 1,
    parameter int MSI_COUNT    = 32,
    // Range code 6 is reported as this BAR index
    parameter int IO_BAR_INDEX = 5
) (
    input  logic                                    clk,
    input  logic                                    rst_n,

    // Receive stream from the IP core
    input  logic [pcie_if_pkg::TLP_DATA_WIDTH-1:0]  rx_st_data,
    input  logic                                    rx_st_sop,
    input  logic                                    rx_st_eop,
    input  logic                                    rx_st_valid,
    input  logic [2:0]                              rx_st_bar_range,
    output logic                                    rx_st_ready,

    // Requests to the BARs
    output logic [pcie_if_pkg::TLP_DATA_WIDTH-1:0]  rx_req_tlp_data,
    output logic                                    rx_req_tlp_sop,
    output logic                                    rx_req_tlp_eop,
    output logic [2:0]                              rx_req_tlp_bar_id,
    output logic                                    rx_req_tlp_valid,
    input  logic                                    rx_req_tlp_ready,

    // Completions to DMA
    output logic [pcie_if_pkg::TLP_DATA_WIDTH-1:0]  rx_cpl_tlp_data,
    output logic                                    rx_cpl_tlp_sop,
    output logic                                    rx_cpl_tlp_eop,
    output logic                                    rx_cpl_tlp_valid,
    input  logic                                    rx_cpl_tlp_ready,

    // Configuration bus and decoded settings
    input  logic [31:0]                             tl_cfg_ctl,
    input  logic [4:0]                              tl_cfg_add,
    input  logic [1:0]                              tl_cfg_func,
    output logic [PF_COUNT-1:0]                     ext_tag_enable,
    output logic [7:0]                              bus_num,
    output logic [PF_COUNT*3-1:0]                   max_payload_size,
    output logic [PF_COUNT*3-1:0]                   max_read_request_size,

    // Interrupts
    input  logic [MSI_COUNT-1:0]                    msi_irq,
    output logic                                    app_msi_req,
    input  logic                                    app_msi_ack,
    output logic [4:0]                              app_msi_num
);

    logic        cfg_msi_enable;
    logic [2:0]  cfg_msi_mme;
    logic [31:0] cfg_msi_mask;

    pcie_if_pkg::rx_beat_t  req_beat;
    pcie_if_pkg::rx_beat_t  req_out;
    logic                   req_valid;
    logic                   req_ready;
    pcie_if_pkg::cpl_beat_t cpl_beat;
    pcie_if_pkg::cpl_beat_t cpl_out;
    logic                   cpl_valid;
    logic                   cpl_ready;

    pcie_cfg_decode #(
        .PF_COUNT(PF_COUNT)
    ) cfg_decode_inst (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .tl_cfg_ctl            (tl_cfg_ctl),
        .tl_cfg_add            (tl_cfg_add),
        .tl_cfg_func           (tl_cfg_func),
        .ext_tag_enable        (ext_tag_enable),
        .max_payload_size      (max_payload_size),
        .max_read_request_size (max_read_request_size),
        .bus_num               (bus_num),
        .msi_enable            (cfg_msi_enable),
        .msi_mme               (cfg_msi_mme),
        .msi_mask              (cfg_msi_mask)
    );

    pcie_msi_gen #(
        .MSI_COUNT(MSI_COUNT)
    ) msi_gen_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .msi_irq     (msi_irq),
        .msi_enable  (cfg_msi_enable),
        .msi_mme     (cfg_msi_mme),
        .msi_mask    (cfg_msi_mask),
        .app_msi_req (app_msi_req),
        .app_msi_ack (app_msi_ack),
        .app_msi_num (app_msi_num)
    );

    pcie_rx_demux #(
        .IO_BAR_INDEX(IO_BAR_INDEX)
    ) rx_demux_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_st_data      (rx_st_data),
        .rx_st_sop       (rx_st_sop),
        .rx_st_eop       (rx_st_eop),
        .rx_st_valid     (rx_st_valid),
        .rx_st_bar_range (rx_st_bar_range),
        .rx_st_ready     (rx_st_ready),
        .req_beat        (req_beat),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .cpl_beat        (cpl_beat),
        .cpl_valid       (cpl_valid),
        .cpl_ready       (cpl_ready)
    );

    // Output slices, one per path
    pcie_tlp_reg #(
        .T(pcie_if_pkg::rx_beat_t)
    ) req_reg_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (req_beat),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .out_data  (req_out),
        .out_valid (rx_req_tlp_valid),
        .out_ready (rx_req_tlp_ready)
    );

    pcie_tlp_reg #(
        .T(pcie_if_pkg::cpl_beat_t)
    ) cpl_reg_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (cpl_beat),
        .in_valid  (cpl_valid),
        .in_ready  (cpl_ready),
        .out_data  (cpl_out),
        .out_valid (rx_cpl_tlp_valid),
        .out_ready (rx_cpl_tlp_ready)
    );

    assign rx_req_tlp_data   = req_out.data;
    assign rx_req_tlp_sop    = req_out.sop;
    assign rx_req_tlp_eop    = req_out.eop;
    assign rx_req_tlp_bar_id = req_out.bar_id;

    assign rx_cpl_tlp_data = cpl_out.data;
    assign rx_cpl_tlp_sop  = cpl_out.sop;
    assign rx_cpl_tlp_eop  = cpl_out.eop;

endmodule

// File: sim/tb_pcie_if.sv
`timescale 1ns/1ns

module tb_pcie_if;

    localparam int CFG_ROWS = 8;
    localparam int RX_ROWS = 8;
    localparam int MSI_ROWS = 6;
    localparam int WATCHDOG_NS = (CFG_ROWS + 2 * RX_ROWS + MSI_ROWS) * 20 * 40;
    localparam logic [4:0] CFG_ADDR_IDLE = 5'h1f;

    typedef struct packed {
        logic [1:0]  func;
        logic [4:0]  addr;
        logic [31:0] ctl;
        logic [1:0]  exp_ext_tag;
        logic [5:0]  exp_mps;
        logic [5:0]  exp_mrrs;
        logic [7:0]  exp_bus;
    } cfg_row_t;

    typedef struct packed {
        logic [1:0] beats;
        logic [4:0] tlp_type;
        logic [2:0] bar_range;
        logic       exp_cpl;
        logic [2:0] exp_bar;
    } rx_row_t;

    typedef struct packed {
        logic [31:0] mask;
        logic [31:0] ctl;
        logic [31:0] irq;
        logic [1:0]  count;
        logic [4:0]  num0;
        logic [4:0]  num1;
        logic [4:0]  num2;
    } msi_row_t;

    typedef struct packed {
        logic [127:0] data;
        logic         sop;
        logic         eop;
        logic [2:0]   bar;
    } exp_beat_t;

    // func, address, ctl word, then ext_tag, mps and mrrs of both functions and bus number
    cfg_row_t cfg_table [CFG_ROWS] = '{
        '{2'd0, pcie_if_pkg::CFG_ADDR_DEVCTL, 32'hffff5f5f, 2'b01, 6'h02, 6'h05, 8'h00},
        '{2'd1, pcie_if_pkg::CFG_ADDR_DEVCTL, 32'h00002160, 2'b11, 6'h1a, 6'h15, 8'h00},
        '{2'd0, pcie_if_pkg::CFG_ADDR_BUSNUM, 32'h000000a7, 2'b11, 6'h1a, 6'h15, 8'ha7},
        '{2'd1, pcie_if_pkg::CFG_ADDR_BUSNUM, 32'hffffff3c, 2'b11, 6'h1a, 6'h15, 8'h3c},
        '{2'd2, pcie_if_pkg::CFG_ADDR_DEVCTL, 32'hffffffff, 2'b11, 6'h1a, 6'h15, 8'h3c},
        '{2'd3, pcie_if_pkg::CFG_ADDR_BUSNUM, 32'h00000055, 2'b11, 6'h1a, 6'h15, 8'h3c},
        '{2'd1, pcie_if_pkg::CFG_ADDR_DEVCTL, 32'h00000000, 2'b01, 6'h02, 6'h05, 8'h3c},
        '{2'd0, 5'h05,                         32'hffffffff, 2'b01, 6'h02, 6'h05, 8'h3c}
    };

    // IO range code 6 is expected back as bar 5
    rx_row_t rx_table [RX_ROWS] = '{
        '{2'd1, 5'b00000, 3'd0, 1'b0, 3'd0},
        '{2'd3, pcie_if_pkg::TLP_TYPE_CPL, 3'd2, 1'b1, 3'd0},
        '{2'd2, 5'b00010, 3'd6, 1'b0, 3'd5},
        '{2'd1, pcie_if_pkg::TLP_TYPE_CPL, 3'd0, 1'b1, 3'd0},
        '{2'd3, 5'b00000, 3'd1, 1'b0, 3'd1},
        '{2'd2, pcie_if_pkg::TLP_TYPE_CPL, 3'd6, 1'b1, 3'd0},
        '{2'd1, 5'b00100, 3'd6, 1'b0, 3'd5},
        '{2'd2, 5'b00000, 3'd4, 1'b0, 3'd4}
    };

    // Pending vectors carry over from one row to the next
    msi_row_t msi_table [MSI_ROWS] = '{
        '{32'h0, 32'h21, 32'h20e, 2'd3, 5'd1, 5'd2, 5'd3},
        '{32'h4, 32'h21, 32'h005, 2'd1, 5'd0, 5'd0, 5'd0},
        '{32'h0, 32'h21, 32'h000, 2'd1, 5'd2, 5'd0, 5'd0},
        '{32'h0, 32'h41, 32'h000, 2'd1, 5'd9, 5'd0, 5'd0},
        '{32'h0, 32'h40, 32'h030, 2'd0, 5'd0, 5'd0, 5'd0},
        '{32'h0, 32'h41, 32'h000, 2'd2, 5'd4, 5'd5, 5'd0}
    };

    logic clk = 1'b0;
    logic rst_n;
    logic [127:0] rx_st_data;
    logic rx_st_sop;
    logic rx_st_eop;
    logic rx_st_valid;
    logic [2:0] rx_st_bar_range;
    logic rx_st_ready;
    logic [127:0] rx_req_tlp_data;
    logic rx_req_tlp_sop;
    logic rx_req_tlp_eop;
    logic [2:0] rx_req_tlp_bar_id;
    logic rx_req_tlp_valid;
    logic rx_req_tlp_ready;
    logic [127:0] rx_cpl_tlp_data;
    logic rx_cpl_tlp_sop;
    logic rx_cpl_tlp_eop;
    logic rx_cpl_tlp_valid;
    logic rx_cpl_tlp_ready;
    logic [31:0] tl_cfg_ctl;
    logic [4:0] tl_cfg_add;
    logic [1:0] tl_cfg_func;
    logic [1:0] ext_tag_enable;
    logic [7:0] bus_num;
    logic [5:0] max_payload_size;
    logic [5:0] max_read_request_size;
    logic [31:0] msi_irq;
    logic app_msi_req;
    logic app_msi_ack;
    logic [4:0] app_msi_num;

    integer seed = 55881;
    integer mismatch_count = 0;
    integer failure_count = 0;
    logic random_ready = 1'b0;
    exp_beat_t req_q[$];
    exp_beat_t cpl_q[$];
    logic req_stalled = 1'b0;
    logic cpl_stalled = 1'b0;
    exp_beat_t req_held;
    exp_beat_t cpl_held;

    pcie_if_top #(
        .PF_COUNT     (2),
        .MSI_COUNT    (32),
        .IO_BAR_INDEX (5)
    ) dut (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .rx_st_data            (rx_st_data),
        .rx_st_sop             (rx_st_sop),
        .rx_st_eop             (rx_st_eop),
        .rx_st_valid           (rx_st_valid),
        .rx_st_bar_range       (rx_st_bar_range),
        .rx_st_ready           (rx_st_ready),
        .rx_req_tlp_data       (rx_req_tlp_data),
        .rx_req_tlp_sop        (rx_req_tlp_sop),
        .rx_req_tlp_eop        (rx_req_tlp_eop),
        .rx_req_tlp_bar_id     (rx_req_tlp_bar_id),
        .rx_req_tlp_valid      (rx_req_tlp_valid),
        .rx_req_tlp_ready      (rx_req_tlp_ready),
        .rx_cpl_tlp_data       (rx_cpl_tlp_data),
        .rx_cpl_tlp_sop        (rx_cpl_tlp_sop),
        .rx_cpl_tlp_eop        (rx_cpl_tlp_eop),
        .rx_cpl_tlp_valid      (rx_cpl_tlp_valid),
        .rx_cpl_tlp_ready      (rx_cpl_tlp_ready),
        .tl_cfg_ctl            (tl_cfg_ctl),
        .tl_cfg_add            (tl_cfg_add),
        .tl_cfg_func           (tl_cfg_func),
        .ext_tag_enable        (ext_tag_enable),
        .bus_num               (bus_num),
        .max_payload_size      (max_payload_size),
        .max_read_request_size (max_read_request_size),
        .msi_irq               (msi_irq),
        .app_msi_req           (app_msi_req),
        .app_msi_ack           (app_msi_ack),
        .app_msi_num           (app_msi_num)
    );

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Error: %s is %0h, expected %0h", name, actual, expected);
        end
    endtask

    function automatic logic [127:0] rand_data();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // One config bus cycle, then back to an unused address
    task automatic write_cfg(input logic [1:0] func, input logic [4:0] addr,
                             input logic [31:0] ctl);
        tl_cfg_func = func;
        tl_cfg_add = addr;
        tl_cfg_ctl = ctl;
        @(negedge clk);
        tl_cfg_func = 2'd0;
        tl_cfg_add = CFG_ADDR_IDLE;
        tl_cfg_ctl = 32'h0;
    endtask

    task automatic send_tlp(input rx_row_t row);
        int b;
        logic [127:0] data;
        exp_beat_t beat;
        for (b = 0; b < row.beats; b++) begin
            data = rand_data();
            if (b == 0) begin
                data[28:24] = row.tlp_type;
            end
            rx_st_data = data;
            rx_st_sop = (b == 0);
            rx_st_eop = (b == row.beats - 1);
            rx_st_valid = 1'b1;
            // Later beats carry junk range codes that must be ignored
            rx_st_bar_range = (b == 0) ? row.bar_range : 3'($random(seed));
            #1;
            while (!rx_st_ready) begin
                @(negedge clk);
                #1;
            end
            beat = '{data, rx_st_sop, rx_st_eop, row.exp_bar};
            if (row.exp_cpl) begin
                cpl_q.push_back(beat);
            end else begin
                req_q.push_back(beat);
            end
            @(negedge clk);
        end
        rx_st_valid = 1'b0;
        rx_st_sop = 1'b0;
        rx_st_eop = 1'b0;
    endtask

    task automatic serve_msi(input logic [4:0] exp_num);
        int waited;
        int hold;
        waited = 0;
        while (!app_msi_req && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!app_msi_req) begin
            failure_count++;
            $display("No MSI request appeared for vector %0d", exp_num);
        end else begin
            check("app_msi_num", app_msi_num, exp_num);
            hold = $random(seed) & 3;
            repeat (hold) begin
                @(negedge clk);
                check("app_msi_req", app_msi_req, 1'b1);
                check("app_msi_num", app_msi_num, exp_num);
            end
            app_msi_ack = 1'b1;
            @(negedge clk);
            app_msi_ack = 1'b0;
            check("app_msi_req", app_msi_req, 1'b0);
        end
    endtask

    // Output ready, random only during the back-pressure pass
    always @(negedge clk) begin
        rx_req_tlp_ready = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
        rx_cpl_tlp_ready = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(negedge clk) begin
        exp_beat_t exp;
        #1;
        if (rst_n) begin
            // Input side is open whenever neither output is back-pressured
            if (rx_req_tlp_ready && rx_cpl_tlp_ready) begin
                check("rx_st_ready", rx_st_ready, 1'b1);
            end
            if (req_stalled) begin
                check("rx_req_tlp_valid", rx_req_tlp_valid, 1'b1);
                check("rx_req_tlp_data", rx_req_tlp_data, req_held.data);
                check("rx_req_tlp_sop", rx_req_tlp_sop, req_held.sop);
                check("rx_req_tlp_eop", rx_req_tlp_eop, req_held.eop);
                check("rx_req_tlp_bar_id", rx_req_tlp_bar_id, req_held.bar);
            end
            if (rx_req_tlp_valid && rx_req_tlp_ready) begin
                if (req_q.size() == 0) begin
                    failure_count++;
                    $display("Request path delivered a beat that was never sent");
                end else begin
                    exp = req_q.pop_front();
                    check("rx_req_tlp_data", rx_req_tlp_data, exp.data);
                    check("rx_req_tlp_sop", rx_req_tlp_sop, exp.sop);
                    check("rx_req_tlp_eop", rx_req_tlp_eop, exp.eop);
                    check("rx_req_tlp_bar_id", rx_req_tlp_bar_id, exp.bar);
                end
            end
            req_stalled = rx_req_tlp_valid && !rx_req_tlp_ready;
            req_held = '{rx_req_tlp_data, rx_req_tlp_sop, rx_req_tlp_eop, rx_req_tlp_bar_id};
        end
    end

    always @(negedge clk) begin
        exp_beat_t exp;
        #1;
        if (rst_n) begin
            if (cpl_stalled) begin
                check("rx_cpl_tlp_valid", rx_cpl_tlp_valid, 1'b1);
                check("rx_cpl_tlp_data", rx_cpl_tlp_data, cpl_held.data);
                check("rx_cpl_tlp_sop", rx_cpl_tlp_sop, cpl_held.sop);
                check("rx_cpl_tlp_eop", rx_cpl_tlp_eop, cpl_held.eop);
            end
            if (rx_cpl_tlp_valid && rx_cpl_tlp_ready) begin
                if (cpl_q.size() == 0) begin
                    failure_count++;
                    $display("Completion path delivered a beat that was never sent");
                end else begin
                    exp = cpl_q.pop_front();
                    check("rx_cpl_tlp_data", rx_cpl_tlp_data, exp.data);
                    check("rx_cpl_tlp_sop", rx_cpl_tlp_sop, exp.sop);
                    check("rx_cpl_tlp_eop", rx_cpl_tlp_eop, exp.eop);
                end
            end
            cpl_stalled = rx_cpl_tlp_valid && !rx_cpl_tlp_ready;
            cpl_held = '{rx_cpl_tlp_data, rx_cpl_tlp_sop, rx_cpl_tlp_eop, 3'd0};
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int drain;
        rst_n = 1'b0;
        rx_st_data = '0;
        rx_st_sop = 1'b0;
        rx_st_eop = 1'b0;
        rx_st_valid = 1'b0;
        rx_st_bar_range = 3'd0;
        rx_req_tlp_ready = 1'b1;
        rx_cpl_tlp_ready = 1'b1;
        tl_cfg_ctl = 32'h0;
        tl_cfg_add = CFG_ADDR_IDLE;
        tl_cfg_func = 2'd0;
        msi_irq = 32'h0;
        app_msi_ack = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        check("app_msi_req", app_msi_req, 1'b0);
        check("rx_req_tlp_valid", rx_req_tlp_valid, 1'b0);
        check("rx_cpl_tlp_valid", rx_cpl_tlp_valid, 1'b0);
        check("ext_tag_enable", ext_tag_enable, 2'b00);
        check("bus_num", bus_num, 8'h00);
        check("max_payload_size", max_payload_size, 6'h00);
        check("max_read_request_size", max_read_request_size, 6'h00);

        for (int i = 0; i < CFG_ROWS; i++) begin
            write_cfg(cfg_table[i].func, cfg_table[i].addr, cfg_table[i].ctl);
            check("ext_tag_enable", ext_tag_enable, cfg_table[i].exp_ext_tag);
            check("max_payload_size", max_payload_size, cfg_table[i].exp_mps);
            check("max_read_request_size", max_read_request_size, cfg_table[i].exp_mrrs);
            check("bus_num", bus_num, cfg_table[i].exp_bus);
        end

        // First pass with open outputs, second with back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            random_ready = (pass == 1);
            for (int i = 0; i < RX_ROWS; i++) begin
                send_tlp(rx_table[i]);
            end
        end
        random_ready = 1'b0;
        drain = 0;
        while ((req_q.size() != 0 || cpl_q.size() != 0) && drain < 50) begin
            @(negedge clk);
            drain++;
        end
        if (req_q.size() != 0 || cpl_q.size() != 0) begin
            failure_count++;
            $display("%0d request and %0d completion beats were never delivered",
                     req_q.size(), cpl_q.size());
        end

        for (int i = 0; i < MSI_ROWS; i++) begin
            write_cfg(2'd0, pcie_if_pkg::CFG_ADDR_MSI_MASK, msi_table[i].mask);
            write_cfg(2'd0, pcie_if_pkg::CFG_ADDR_MSI_CTL, msi_table[i].ctl);
            msi_irq = msi_table[i].irq;
            @(negedge clk);
            msi_irq = 32'h0;
            if (msi_table[i].count > 0) serve_msi(msi_table[i].num0);
            if (msi_table[i].count > 1) serve_msi(msi_table[i].num1);
            if (msi_table[i].count > 2) serve_msi(msi_table[i].num2);
            repeat (6) begin
                @(negedge clk);
                if (app_msi_req) begin
                    failure_count++;
                    $display("Unexpected MSI request for vector %0d", app_msi_num);
                end
            end
        end

        $display("Error counts: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/pcie_if_pkg.sv
verilog/pcie_cfg_decode.sv
verilog/pcie_msi_gen.sv
verilog/pcie_rx_demux.sv
verilog/pcie_tlp_reg.sv
verilog/pcie_if_top.sv
sim/tb_pcie_if.sv

// File: Bender.yml
package:
  name: pcie_if

sources:
  - files:
      - verilog/pcie_if_pkg.sv
      - verilog/pcie_cfg_decode.sv
      - verilog/pcie_msi_gen.sv
      - verilog/pcie_rx_demux.sv
      - verilog/pcie_tlp_reg.sv
      - verilog/pcie_if_top.sv
  - target: simulation
    files:
      - sim/tb_pcie_if.sv
